/* bench/div_ref_model.svh */
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// ****************************************
// reference model of the divide stage.
// ****************************************

logic [`DATA_W-1:0] shadow_regs [`REG_COUNT];

// number of significant bits, zero for a zero value.
function automatic int significant_bits(input logic [`DATA_W-1:0] v);
    int bits;
    bits = 0;
    for (int i = 0; i < `DATA_W; i++) begin
        if (v[i]) begin
            bits = i + 1;
        end
    end
    return bits;
endfunction

function automatic logic [`DATA_W-1:0] magnitude(input logic [`DATA_W-1:0] v,
                                                 input logic neg);
    return neg ? -v : v;
endfunction

// the dividend is shorter than the divisor, or the divisor is zero.
function automatic bit early_out_case(input div_pkg::div_req_t r);
    logic [`DATA_W-1:0] a_mag;
    logic [`DATA_W-1:0] b_mag;
    a_mag = magnitude(r.dividend, r.sign && r.dividend[`DATA_W-1]);
    b_mag = magnitude(r.divisor, r.sign && r.divisor[`DATA_W-1]);
    return (b_mag == '0) || (significant_bits(a_mag) < significant_bits(b_mag));
endfunction

function automatic div_pkg::div_resp_t expected_resp(input div_pkg::div_req_t r);
    logic               a_neg;
    logic               b_neg;
    logic [`DATA_W-1:0] a_mag;
    logic [`DATA_W-1:0] b_mag;
    logic [`DATA_W-1:0] quot;
    logic [`DATA_W-1:0] rem;
    div_pkg::div_resp_t e;
    a_neg = r.sign && r.dividend[`DATA_W-1];
    b_neg = r.sign && r.divisor[`DATA_W-1];
    a_mag = magnitude(r.dividend, a_neg);
    b_mag = magnitude(r.divisor, b_neg);
    if (early_out_case(r)) begin
        quot = '0;
        rem  = r.dividend;  // raw dividend, no sign fix.
    end else begin
        quot = a_mag / b_mag;  // truncates toward zero on magnitudes.
        rem  = a_mag % b_mag;
        quot = magnitude(quot, a_neg != b_neg);
        rem  = magnitude(rem, a_neg);
    end
    e.en     = 1'b1;
    e.result = (r.op == div_pkg::DIV_REM) ? rem : quot;
    e.addr   = r.addr;
    return e;
endfunction

task automatic clear_shadow();
    for (int i = 0; i < `REG_COUNT; i++) begin
        shadow_regs[i] = '0;
    end
endtask

task automatic shadow_write(input div_pkg::div_resp_t e);
    if (e.addr != '0) begin
        shadow_regs[e.addr] = e.result;  // register zero stays zero.
    end
endtask

// ****************************************
// compare tasks.
// ****************************************

task automatic compare_resp(input div_pkg::div_resp_t got, input div_pkg::div_resp_t want,
                            input string what);
    if (got !== want) begin
        $display("Error at %0t: %s mismatch, got en=%0b result=%08h addr=%0d",
                 $time, what, got.en, got.result, got.addr);
        $display("    expected en=%0b result=%08h addr=%0d", want.en, want.result, want.addr);
        abort_run();
    end
endtask

task automatic compare_reg(input logic [`REG_ADDR_W-1:0] addr,
                           input logic [`DATA_W-1:0] got);
    if (got !== shadow_regs[addr]) begin
        $display("Error at %0t: register %0d reads %08h, expected %08h",
                 $time, addr, got, shadow_regs[addr]);
        abort_run();
    end
endtask

`endif

/* bench/tb_div_stage.sv */
`timescale 1ns/10ps

`include "div_consts.svh"

module tb_div_stage;

    localparam int N_REQ     = 200;
    localparam int N_SINGLE  = 8;   // early-out requests sent one at a time.
    localparam int N_CORNER  = 8;
    // no request needs more than about 40 cycles, plus reset and readback.
    localparam int TIMEOUT_CYCLES = N_REQ * 40 + 200;

    logic                   clk;
    logic                   reset;
    div_pkg::div_req_t      req;
    logic                   full;
    logic                   busy;
    div_pkg::div_resp_t     resp;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`DATA_W-1:0]     rd_data;

    integer seed;
    int     sent = 0;
    int     received = 0;
    int     cycle_count = 0;
    bit     saw_full = 1'b0;

    div_pkg::div_resp_t expected_q [$];

    div_stage_top DUT (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .full    (full),
        .busy    (busy),
        .resp    (resp),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    `include "div_ref_model.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timed out after %0d cycles with %0d of %0d responses seen",
                 cycle_count, received, sent);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    // ****************************************
    // stimulus helpers.
    // ****************************************

    function automatic logic [`DATA_W-1:0] random_operand();
        logic [`DATA_W-1:0] raw;
        int unsigned        kind;
        raw  = $random(seed);
        kind = {$random(seed)} % 8;
        case (kind)
            0:       return '0;
            1:       return raw & 32'h0000_000f;  // small values.
            2:       return 32'h8000_0000;
            3:       return 32'hffff_ffff;
            4:       return raw >> raw[4:0];      // spread the bit lengths.
            default: return raw;
        endcase
    endfunction

    function automatic div_pkg::div_req_t make_request(input div_pkg::div_op_e op,
                                                       input logic sign,
                                                       input logic [`DATA_W-1:0] dividend,
                                                       input logic [`DATA_W-1:0] divisor,
                                                       input logic [`REG_ADDR_W-1:0] addr);
        div_pkg::div_req_t r;
        r.en       = 1'b1;
        r.op       = op;
        r.sign     = sign;
        r.dividend = dividend;
        r.divisor  = divisor;
        r.addr     = addr;
        return r;
    endfunction

    function automatic div_pkg::div_req_t random_request();
        div_pkg::div_op_e op;
        logic             sign;
        op   = ($random(seed) & 1) ? div_pkg::DIV_REM : div_pkg::DIV_QUOT;
        sign = 1'($random(seed));
        return make_request(op, sign, random_operand(), random_operand(),
                            `REG_ADDR_W'($random(seed)));
    endfunction

    // small dividend against a wide or zero divisor.
    function automatic div_pkg::div_req_t early_out_request(input int idx);
        div_pkg::div_req_t  r;
        logic [`DATA_W-1:0] raw;
        r          = random_request();
        raw        = $random(seed);
        r.dividend = raw & 32'h0000_000f;
        if (r.sign && raw[4]) begin
            r.dividend = -r.dividend;
        end
        r.divisor = (idx % 2 == 0) ? '0 : ({1'b0, raw[`DATA_W-2:0]} | 32'h0000_0100);
        return r;
    endfunction

    task automatic send_req(input div_pkg::div_req_t r);
        @(negedge clk);
        while (full) begin
            @(negedge clk);
        end
        @(posedge clk);
        req <= r;
        expected_q.push_back(expected_resp(r));
        sent++;
        @(posedge clk);
        req.en <= 1'b0;  // one-cycle strobe.
    endtask

    task automatic check_early_latency();
        @(negedge clk);
        while (!busy) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (!resp.en) begin
            $display("Error at %0t: early-out result not one cycle after accept", $time);
            abort_run();
        end
    endtask

    // ****************************************
    // response monitor.
    // ****************************************

    always @(negedge clk) begin
        div_pkg::div_resp_t want;
        if (!reset) begin
            if (full) begin
                saw_full = 1'b1;
                if (sent - received < `ISSUE_DEPTH) begin
                    $display("Error at %0t: full with only %0d requests outstanding",
                             $time, sent - received);
                    abort_run();
                end
            end
            if (resp.en) begin
                if (expected_q.size() == 0) begin
                    $display("Error at %0t: response with no request outstanding", $time);
                    abort_run();
                end else begin
                    want = expected_q.pop_front();
                    compare_resp(resp, want, "response");
                    shadow_write(want);
                    received++;
                end
            end
        end
    end

    initial begin
        div_pkg::div_req_t r;
        $timeformat(-9, 0, " ns", 0);
        seed    = 39;
        req     = '0;
        rd_addr = '0;
        reset   = 1'b1;
        clear_shadow();
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        compare_resp(resp, '0, "reset response");
        if (busy || full) begin
            $display("Error at %0t: busy or full high after reset", $time);
            abort_run();
        end

        // single early-out requests into an idle stage.
        for (int i = 0; i < N_SINGLE; i++) begin
            r = early_out_request(i);
            while (busy || received != sent) begin
                @(negedge clk);
            end
            send_req(r);
            check_early_latency();
        end

        // signed corner cases, then a random burst.
        send_req(make_request(div_pkg::DIV_QUOT, 1'b1, 32'h8000_0000, 32'hffff_ffff, 5'd1));
        send_req(make_request(div_pkg::DIV_REM, 1'b1, 32'h8000_0000, 32'hffff_ffff, 5'd2));
        send_req(make_request(div_pkg::DIV_QUOT, 1'b1, -32'sd7, 32'd2, 5'd3));
        send_req(make_request(div_pkg::DIV_REM, 1'b1, -32'sd7, 32'd2, 5'd4));
        send_req(make_request(div_pkg::DIV_QUOT, 1'b1, 32'd7, -32'sd2, 5'd5));
        send_req(make_request(div_pkg::DIV_REM, 1'b1, 32'd7, -32'sd2, 5'd0));
        send_req(make_request(div_pkg::DIV_QUOT, 1'b0, 32'hffff_ffff, 32'd0, 5'd6));
        send_req(make_request(div_pkg::DIV_REM, 1'b0, 32'h8000_0000, 32'hffff_ffff, 5'd7));
        for (int i = 0; i < N_REQ - N_SINGLE - N_CORNER; i++) begin
            send_req(random_request());
        end

        while (received < sent) begin
            @(negedge clk);
        end
        repeat (40) @(negedge clk);  // no stray pulses after the last one.
        if (!saw_full) begin
            $display("the queue never reported full during the burst");
            abort_run();
        end

        for (int a = 0; a < `REG_COUNT; a++) begin
            @(posedge clk);
            rd_addr <= `REG_ADDR_W'(a);
            @(negedge clk);
            compare_reg(`REG_ADDR_W'(a), rd_data);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
+incdir+bench
hw/div_pkg.sv
hw/log2_plus_one.sv
hw/div_unit.sv
hw/div_issue_queue.sv
hw/div_result_regfile.sv
hw/div_stage_top.sv
bench/tb_div_stage.sv

/* hw/div_consts.svh */
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// ****************************************
// divide stage widths and depths.
// ****************************************

`define DATA_W       32  // operand and result width.
`define REG_ADDR_W   5   // destination register address width.
`define REG_COUNT    32  // number of destination registers.

// requests that may wait behind the one in flight.
`define ISSUE_DEPTH  4

`endif

/* hw/div_issue_queue.sv */
`timescale 1ns/10ps

`include "div_consts.svh"

// Small circular buffer of divide requests in front of the divider.
module div_issue_queue (
    input  logic               clk,
    input  logic               reset,
    input  div_pkg::div_req_t  req,
    input  logic               ready,
    output div_pkg::div_req_t  issue,
    output logic               full
);

    localparam int PTR_W = $clog2(`ISSUE_DEPTH);
    localparam int CNT_W = $clog2(`ISSUE_DEPTH + 1);

    div_pkg::div_req_t mem [`ISSUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(`ISSUE_DEPTH));
    assign push = req.en && !full;
    assign pop  = ready && issue.en;  // divider takes the head on this edge.

    always_comb begin
        issue    = mem[rd_ptr];
        issue.en = (count != '0);
    end

    // ****************************************
    // pointers and fill level.
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`ISSUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`ISSUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

endmodule

/* hw/div_pkg.sv */
`include "div_consts.svh"

package div_pkg;

    // ****************************************
    // opcodes and divider phases.
    // ****************************************

    typedef enum logic {
        DIV_QUOT = 1'b0,  // result is the quotient.
        DIV_REM  = 1'b1   // result is the remainder.
    } div_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE   = 2'd0,
        DIV_ITER   = 2'd1,
        DIV_FINISH = 2'd2,
        DIV_DONE   = 2'd3
    } div_state_e;

    // ****************************************
    // request and response records.
    // ****************************************

    typedef struct packed {
        logic                    en;
        div_op_e                 op;
        logic                    sign;      // one for a signed divide.
        logic [`DATA_W-1:0]      dividend;
        logic [`DATA_W-1:0]      divisor;
        logic [`REG_ADDR_W-1:0]  addr;
    } div_req_t;

    typedef struct packed {
        logic                    en;
        logic [`DATA_W-1:0]      result;
        logic [`REG_ADDR_W-1:0]  addr;
    } div_resp_t;

endpackage

/* hw/div_result_regfile.sv */
`timescale 1ns/10ps

`include "div_consts.svh"

// Destination registers written by divider results.
// Register zero is hardwired to zero.
module div_result_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  div_pkg::div_resp_t     resp,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    output logic [`DATA_W-1:0]     rd_data
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (resp.en && (resp.addr != '0)) begin
            regs[resp.addr] <= resp.result;
        end
    end

    // read port is combinational.
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

/* hw/div_stage_top.sv */
`timescale 1ns/10ps

`include "div_consts.svh"

// Divide stage: issue queue, iterative divider and result registers.
module div_stage_top (
    input  logic                   clk,
    input  logic                   reset,
    input  div_pkg::div_req_t      req,
    output logic                   full,
    output logic                   busy,
    output div_pkg::div_resp_t     resp,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    output logic [`DATA_W-1:0]     rd_data
);

    div_pkg::div_req_t issue;
    logic              ready;

    div_issue_queue u_queue (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ready (ready),
        .issue (issue),
        .full  (full)
    );

    div_unit u_div (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .ready (ready),
        .busy  (busy),
        .resp  (resp)  // also leaves the stage unchanged.
    );

    div_result_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .resp    (resp),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* hw/div_unit.sv */
`timescale 1ns/10ps

`include "div_consts.svh"

// Restoring divider, one quotient bit per cycle.
// Only the significant bit positions of the operands are iterated.
module div_unit (
    input  logic                clk,
    input  logic                reset,
    input  div_pkg::div_req_t   issue,
    output logic                ready,
    output logic                busy,
    output div_pkg::div_resp_t  resp
);

    // ****************************************
    // operand magnitudes and bit lengths.
    // ****************************************

    logic [`DATA_W-1:0] a_mag;
    logic [`DATA_W-1:0] b_mag;
    logic [5:0]         m;
    logic [5:0]         n;
    logic [5:0]         span;
    logic               early_out;
    logic               dividend_neg;
    logic               divisor_neg;

    assign dividend_neg = issue.sign && issue.dividend[`DATA_W-1];
    assign divisor_neg  = issue.sign && issue.divisor[`DATA_W-1];

    assign a_mag = dividend_neg ? (~issue.dividend + 1'b1) : issue.dividend;
    assign b_mag = divisor_neg ? (~issue.divisor + 1'b1) : issue.divisor;

    log2_plus_one u_log2_dividend (
        .value (a_mag),
        .pos   (m)
    );

    log2_plus_one u_log2_divisor (
        .value (b_mag),
        .pos   (n)
    );

    assign early_out = (m < n) || (n == 6'd0);  // nothing to iterate.
    assign span      = m - n;

    // ****************************************
    // state and datapath registers.
    // ****************************************

    div_pkg::div_state_e state;
    logic [5:0]          step_cnt;

    logic [2*`DATA_W-1:0]   rem;
    logic [2*`DATA_W-1:0]   dvs;
    logic [`DATA_W-1:0]     quot;
    div_pkg::div_op_e       op_q;
    logic                   dividend_sign;
    logic                   divisor_sign;
    logic [`REG_ADDR_W-1:0] addr_q;

    logic               accept;
    logic               step_sub;
    logic [`DATA_W-1:0] rem_fixed;
    logic [`DATA_W-1:0] quot_fixed;

    assign ready  = (state == div_pkg::DIV_IDLE);
    assign accept = ready && issue.en;

    assign step_sub = (rem >= dvs);

    // the remainder follows the dividend, the quotient the sign difference.
    assign rem_fixed  = dividend_sign ? (~rem[`DATA_W-1:0] + 1'b1) : rem[`DATA_W-1:0];
    assign quot_fixed = (dividend_sign != divisor_sign) ? (~quot + 1'b1) : quot;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= div_pkg::DIV_IDLE;
            step_cnt <= 6'd0;
            busy     <= 1'b0;
            resp     <= '0;
        end else begin
            case (state)
                div_pkg::DIV_IDLE: begin
                    if (accept) begin
                        busy <= 1'b1;
                        if (early_out) begin
                            state <= div_pkg::DIV_FINISH;
                        end else begin
                            state    <= div_pkg::DIV_ITER;
                            step_cnt <= span;  // span + 1 subtract steps.
                        end
                    end
                end
                div_pkg::DIV_ITER: begin
                    if (step_cnt == 6'd0) begin
                        state <= div_pkg::DIV_FINISH;
                    end else begin
                        step_cnt <= step_cnt - 6'd1;
                    end
                end
                div_pkg::DIV_FINISH: begin
                    state       <= div_pkg::DIV_DONE;
                    busy        <= 1'b0;
                    resp.en     <= 1'b1;
                    resp.result <= (op_q == div_pkg::DIV_REM) ? rem_fixed : quot_fixed;
                    resp.addr   <= addr_q;
                end
                default: begin
                    state <= div_pkg::DIV_IDLE;  // one dead cycle after the pulse.
                    resp  <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= issue.op;
            addr_q <= issue.addr;
            quot   <= '0;
            if (early_out) begin
                // raw dividend goes out unchanged as the remainder.
                rem           <= {{`DATA_W{1'b0}}, issue.dividend};
                dvs           <= '0;
                dividend_sign <= 1'b0;
                divisor_sign  <= 1'b0;
            end else begin
                rem           <= {{`DATA_W{1'b0}}, a_mag};
                dvs           <= {{`DATA_W{1'b0}}, b_mag} << span;
                dividend_sign <= dividend_neg;
                divisor_sign  <= divisor_neg;
            end
        end else if (state == div_pkg::DIV_ITER) begin
            if (step_sub) begin
                rem  <= rem - dvs;
                quot <= {quot[`DATA_W-2:0], 1'b1};
            end else begin
                quot <= {quot[`DATA_W-2:0], 1'b0};
            end
            dvs <= dvs >> 1;
        end
    end

endmodule

/* hw/log2_plus_one.sv */
`timescale 1ns/10ps

`include "div_consts.svh"

// Returns the position of the highest set bit plus one.
// A zero input gives zero, a value with bit 31 set gives 32.
module log2_plus_one (
    input  logic [`DATA_W-1:0] value,
    output logic [5:0]         pos
);

    logic found;

    always_comb begin
        pos   = 6'd0;
        found = 1'b0;
        // scan down from the top bit and keep the first one seen.
        for (int i = `DATA_W - 1; i >= 0; i--) begin
            if (!found && value[i]) begin
                pos   = 6'(i + 1);
                found = 1'b1;
            end
        end
    end

endmodule
